// ==== verilog/ahb3_pkg.sv ====
// AHB3 bus encodings shared by the memory-access master and the SRAM slave
package ahb3_pkg;

  // Only idle and non-sequential transfer types are ever issued
  typedef enum logic [1:0] {
    IDLE   = 2'b00,
    NONSEQ = 2'b10
  } htrans_t;

  // Burst type
  typedef enum logic [2:0] {
    SINGLE = 3'b000, // Bus parked between accesses
    INCR   = 3'b010, // Incrementing burst, more beats follow
    END    = 3'b111  // Final beat of a burst or a single access
  } hburst_t;

  // Full 32-bit word transfer
  localparam logic [2:0] HSIZE_WORD = 3'b010;

endpackage

// ==== verilog/mam_req_pkg.sv ====
// Memory-access request fields and channel indexing shared by the arbiter, master and top level
package mam_req_pkg;

  // Burst length field of a request, counted in bus words
  localparam int BEATS_W = 13;

  typedef logic [BEATS_W-1:0] beats_t;

  // Number of peer memory-access channels sharing the bus
  localparam int NCHAN = 2;

  // Selects one channel
  typedef logic [$clog2(NCHAN)-1:0] chan_idx_t;

endpackage

// ==== verilog/mam_ahb_master.sv ====
// AHB3 bus master turning one memory-access request into single or incrementing burst beats
module mam_ahb_master #(
  parameter int XLEN = 32,
  parameter int PLEN = 32
) (
  input  logic                clk_i,
  input  logic                rst_i,

  input  logic                req_valid_i,
  output logic                req_ready_o,
  input  logic                req_we_i,    // 1 for write, 0 for read
  input  logic [PLEN-1:0]     req_addr_i,  // Base address
  input  logic                req_burst_i, // 1 for incrementing burst
  input  mam_req_pkg::beats_t req_beats_i,

  input  logic                write_valid_i,
  input  logic [XLEN-1:0]     write_data_i,
  output logic                write_ready_o,

  output logic                read_valid_o,
  output logic [XLEN-1:0]     read_data_o,
  input  logic                read_ready_i,

  output logic                ahb_hsel_o,
  output logic [PLEN-1:0]     ahb_haddr_o,
  output logic [XLEN-1:0]     ahb_hwdata_o,
  input  logic [XLEN-1:0]     ahb_hrdata_i,
  output logic                ahb_hwrite_o,
  output logic [2:0]          ahb_hsize_o,
  output ahb3_pkg::hburst_t   ahb_hburst_o,
  output ahb3_pkg::htrans_t   ahb_htrans_o,
  input  logic                ahb_hready_i
);
  import ahb3_pkg::*;
  import mam_req_pkg::*;

  localparam logic [PLEN-1:0] ADDR_STEP = PLEN'(XLEN / 8);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_WRITE,
    ST_WRITE_WAIT,
    ST_WRITE_LAST,
    ST_WRITE_LAST_WAIT,
    ST_READ,
    ST_READ_WAIT
  } state_t;

  state_t          state;
  state_t          nxt_state;
  beats_t          beats;
  beats_t          nxt_beats;
  beats_t          req_len;
  hburst_t         nxt_hburst;
  logic [PLEN-1:0] nxt_haddr;
  logic            nxt_hwrite;
  logic [XLEN-1:0] nxt_hwdata;
  logic [XLEN-1:0] nxt_rdata;

  // A single access is handled as a one-beat burst
  assign req_len = req_burst_i ? req_beats_i : beats_t'(1);

  assign ahb_hsize_o  = HSIZE_WORD;
  assign ahb_htrans_o = ahb_hsel_o ? NONSEQ : IDLE;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state        <= ST_IDLE;
      ahb_hburst_o <= SINGLE;
    end else begin
      state        <= nxt_state;
      ahb_hburst_o <= nxt_hburst;
    end
    ahb_haddr_o  <= nxt_haddr;
    ahb_hwrite_o <= nxt_hwrite;
    ahb_hwdata_o <= nxt_hwdata;
    read_data_o  <= nxt_rdata;
    beats        <= nxt_beats;
  end

  always_comb begin
    nxt_state     = state;
    nxt_beats     = beats;
    nxt_hburst    = ahb_hburst_o;
    nxt_haddr     = ahb_haddr_o;
    nxt_hwrite    = ahb_hwrite_o;
    nxt_hwdata    = ahb_hwdata_o;
    nxt_rdata     = read_data_o;
    req_ready_o   = 1'b0;
    write_ready_o = 1'b0;
    read_valid_o  = 1'b0;
    ahb_hsel_o    = 1'b0;

    case (state)
      ST_IDLE: begin
        req_ready_o = 1'b1;
        if (req_valid_i) begin
          nxt_haddr  = req_addr_i;
          nxt_hwrite = req_we_i;
          nxt_beats  = req_len;
          nxt_hburst = (req_len == beats_t'(1)) ? END : INCR;
          if (!req_we_i) begin
            nxt_state = ST_READ;
          end else if (req_len == beats_t'(1)) begin
            nxt_state = ST_WRITE_LAST_WAIT;
          end else begin
            nxt_state = ST_WRITE_WAIT;
          end
        end
      end

      ST_WRITE_WAIT: begin
        write_ready_o = 1'b1;
        if (write_valid_i) begin
          nxt_hwdata = write_data_i;
          nxt_beats  = beats - 1'b1;
          nxt_state  = ST_WRITE;
        end
      end

      ST_WRITE: begin
        ahb_hsel_o = 1'b1;
        if (ahb_hready_i) begin
          // Next word can be taken while this beat completes
          write_ready_o = 1'b1;
          nxt_haddr     = ahb_haddr_o + ADDR_STEP;
          if (beats == beats_t'(1)) begin
            nxt_hburst = END;
            nxt_state  = write_valid_i ? ST_WRITE_LAST : ST_WRITE_LAST_WAIT;
            if (write_valid_i) begin
              nxt_hwdata = write_data_i;
            end
          end else if (write_valid_i) begin
            nxt_hwdata = write_data_i;
            nxt_beats  = beats - 1'b1;
          end else begin
            nxt_state = ST_WRITE_WAIT;
          end
        end
      end

      ST_WRITE_LAST_WAIT: begin
        write_ready_o = 1'b1;
        if (write_valid_i) begin
          nxt_hwdata = write_data_i;
          nxt_state  = ST_WRITE_LAST;
        end
      end

      ST_WRITE_LAST: begin
        ahb_hsel_o = 1'b1;
        if (ahb_hready_i) begin
          nxt_hburst = SINGLE;
          nxt_state  = ST_IDLE;
        end
      end

      ST_READ: begin
        ahb_hsel_o = 1'b1;
        if (ahb_hready_i) begin
          nxt_rdata = ahb_hrdata_i;
          nxt_beats = beats - 1'b1;
          nxt_haddr = ahb_haddr_o + ADDR_STEP;
          nxt_state = ST_READ_WAIT;
        end
      end

      ST_READ_WAIT: begin
        // Bus stays idle here until the channel has credit
        read_valid_o = 1'b1;
        if (read_ready_i) begin
          if (beats == '0) begin
            nxt_hburst = SINGLE;
            nxt_state  = ST_IDLE;
          end else begin
            if (beats == beats_t'(1)) begin
              nxt_hburst = END;
            end
            nxt_state = ST_READ;
          end
        end
      end

      default: nxt_state = ST_IDLE;
    endcase
  end

  // Address phase held by the master across all slave wait states
  a_addr_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    ahb_hsel_o && !ahb_hready_i |=> ahb_hsel_o && $stable(ahb_haddr_o) && $stable(ahb_hwrite_o));

endmodule

// ==== verilog/mam_arbiter.sv ====
// Round-robin arbiter giving one memory-access channel at a time to the bus master
module mam_arbiter #(
  parameter int CREDITS = 2,
  parameter int XLEN    = 32,
  parameter int PLEN    = 32
) (
  input  logic                                      clk_i,
  input  logic                                      rst_i,

  input  logic [mam_req_pkg::NCHAN-1:0]             chan_req_valid_i,
  output logic [mam_req_pkg::NCHAN-1:0]             chan_req_ready_o,
  input  logic [mam_req_pkg::NCHAN-1:0]             chan_req_we_i,
  input  logic [mam_req_pkg::NCHAN-1:0][PLEN-1:0]   chan_req_addr_i,
  input  logic [mam_req_pkg::NCHAN-1:0]             chan_req_burst_i,
  input  mam_req_pkg::beats_t [mam_req_pkg::NCHAN-1:0] chan_req_beats_i,
  input  logic [mam_req_pkg::NCHAN-1:0]             chan_write_valid_i,
  input  logic [mam_req_pkg::NCHAN-1:0][XLEN-1:0]   chan_write_data_i,
  output logic [mam_req_pkg::NCHAN-1:0]             chan_write_ready_o,
  output logic [mam_req_pkg::NCHAN-1:0]             chan_read_valid_o,
  output logic [mam_req_pkg::NCHAN-1:0][XLEN-1:0]   chan_read_data_o,
  input  logic [mam_req_pkg::NCHAN-1:0]             chan_read_credit_i,

  output logic                                      mst_req_valid_o,
  input  logic                                      mst_req_ready_i,
  output logic                                      mst_req_we_o,
  output logic [PLEN-1:0]                           mst_req_addr_o,
  output logic                                      mst_req_burst_o,
  output mam_req_pkg::beats_t                       mst_req_beats_o,
  output logic                                      mst_write_valid_o,
  output logic [XLEN-1:0]                           mst_write_data_o,
  input  logic                                      mst_write_ready_i,
  input  logic                                      mst_read_valid_i,
  input  logic [XLEN-1:0]                           mst_read_data_i,
  output logic                                      mst_read_ready_o
);
  import mam_req_pkg::*;

  localparam int CW = $clog2(CREDITS + 1);

  chan_idx_t     grant;
  chan_idx_t     last_win; // Channel that won the previous arbitration
  chan_idx_t     pick;
  logic          locked;
  logic          accept;
  logic [CW-1:0] credit [NCHAN];

  assign accept = mst_req_valid_o && mst_req_ready_i;

  // Granted channel drives the master
  assign mst_req_valid_o   = chan_req_valid_i[grant] && !locked;
  assign mst_req_we_o      = chan_req_we_i[grant];
  assign mst_req_addr_o    = chan_req_addr_i[grant];
  assign mst_req_burst_o   = chan_req_burst_i[grant];
  assign mst_req_beats_o   = chan_req_beats_i[grant];
  assign mst_write_valid_o = chan_write_valid_i[grant];
  assign mst_write_data_o  = chan_write_data_i[grant];
  assign mst_read_ready_o  = (credit[grant] != '0);

  always_comb begin
    for (int c = 0; c < NCHAN; c++) begin
      chan_req_ready_o[c]   = (grant == chan_idx_t'(c)) && mst_req_ready_i && !locked;
      chan_write_ready_o[c] = (grant == chan_idx_t'(c)) && mst_write_ready_i;
      chan_read_valid_o[c]  = (grant == chan_idx_t'(c)) && mst_read_valid_i && mst_read_ready_o;
      chan_read_data_o[c]   = mst_read_data_i;
    end
  end

  // Farthest candidate checked first so the nearest requester after the last winner wins
  always_comb begin
    chan_idx_t cand;
    pick = grant;
    for (int i = NCHAN; i >= 1; i--) begin
      cand = chan_idx_t'((int'(last_win) + i) % NCHAN);
      if (chan_req_valid_i[cand]) begin
        pick = cand;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      grant    <= '0;
      last_win <= chan_idx_t'(NCHAN - 1);
      locked   <= 1'b0;
    end else if (accept) begin
      locked   <= 1'b1;
      last_win <= grant;
    end else if (!locked || mst_req_ready_i) begin
      locked <= 1'b0; // Master back in idle ends the access
      grant  <= pick;
    end
  end

  // Read credits where a delivered beat spends one and a credit pulse returns one
  always_ff @(posedge clk_i) begin
    for (int c = 0; c < NCHAN; c++) begin
      if (rst_i) begin
        credit[c] <= CW'(CREDITS);
      end else if (chan_read_credit_i[c] && !chan_read_valid_o[c]) begin
        if (credit[c] != CW'(CREDITS)) begin
          credit[c] <= credit[c] + 1'b1;
        end
      end else if (!chan_read_credit_i[c] && chan_read_valid_o[c]) begin
        credit[c] <= credit[c] - 1'b1;
      end
    end
  end

  // Grant held for as long as the master works on an accepted request
  a_grant_locked: assert property (@(posedge clk_i) disable iff (rst_i)
    !mst_req_ready_i |-> locked && $stable(grant));

  // A channel only returns credits it has spent
  for (genvar c = 0; c < NCHAN; c++) begin : g_credit_chk
    a_credit_max: assert property (@(posedge clk_i) disable iff (rst_i)
      chan_read_credit_i[c] && !chan_read_valid_o[c] |-> credit[c] != CW'(CREDITS));
  end

endmodule

// ==== verilog/mam_ahb_sram.sv ====
// AHB3 slave word memory that stretches every beat by a fixed number of wait states
module mam_ahb_sram #(
  parameter int XLEN        = 32,
  parameter int PLEN        = 32,
  parameter int MEM_WORDS   = 256,
  parameter int WAIT_STATES = 2
) (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              ahb_hsel_i,
  input  logic [PLEN-1:0]   ahb_haddr_i,
  input  logic [XLEN-1:0]   ahb_hwdata_i,
  input  logic              ahb_hwrite_i,
  input  ahb3_pkg::htrans_t ahb_htrans_i,
  input  ahb3_pkg::hburst_t ahb_hburst_i,
  output logic [XLEN-1:0]   ahb_hrdata_o,
  output logic              ahb_hready_o
);
  import ahb3_pkg::*;

  localparam int AW  = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;
  localparam int OFS = $clog2(XLEN / 8); // Byte offset bits within a word
  localparam int WW  = (WAIT_STATES > 0) ? $clog2(WAIT_STATES + 1) : 1;

  logic [XLEN-1:0] mem [MEM_WORDS];
  logic [AW-1:0]   word_idx;
  logic [WW-1:0]   wait_cnt;
  logic            active;

  assign active   = ahb_hsel_i && (ahb_htrans_i != IDLE);
  assign word_idx = ahb_haddr_i[OFS +: AW];

  // Beat completes once the wait counter has run down
  assign ahb_hready_o = active && (wait_cnt == '0);
  assign ahb_hrdata_o = mem[word_idx];

  // Reloaded between beats so each beat sees the full wait
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wait_cnt <= WW'(WAIT_STATES);
    end else if (!active || ahb_hready_o) begin
      wait_cnt <= WW'(WAIT_STATES);
    end else begin
      wait_cnt <= wait_cnt - 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (ahb_hready_o && ahb_hwrite_i) begin
      mem[word_idx] <= ahb_hwdata_i;
    end
  end

  // Master releases the bus after a beat marked as last
  a_end_release: assert property (@(posedge clk_i) disable iff (rst_i)
    ahb_hready_o && (ahb_hburst_i == END) |=> !ahb_hsel_i);

endmodule

// ==== verilog/mam_sys_top.sv ====
// Debug memory-access subsystem with two channels sharing one AHB3 master and SRAM slave
module mam_sys_top #(
  parameter int XLEN        = 32,
  parameter int PLEN        = 32,
  parameter int MEM_WORDS   = 256,
  parameter int WAIT_STATES = 2,
  parameter int CREDITS     = 2
) (
  input  logic                clk_i,
  input  logic                rst_i,

  input  logic                ch0_req_valid_i,
  output logic                ch0_req_ready_o,
  input  logic                ch0_req_we_i,
  input  logic [PLEN-1:0]     ch0_req_addr_i,
  input  logic                ch0_req_burst_i,
  input  mam_req_pkg::beats_t ch0_req_beats_i,
  input  logic                ch0_write_valid_i,
  input  logic [XLEN-1:0]     ch0_write_data_i,
  output logic                ch0_write_ready_o,
  output logic                ch0_read_valid_o,
  output logic [XLEN-1:0]     ch0_read_data_o,
  input  logic                ch0_read_credit_i,

  input  logic                ch1_req_valid_i,
  output logic                ch1_req_ready_o,
  input  logic                ch1_req_we_i,
  input  logic [PLEN-1:0]     ch1_req_addr_i,
  input  logic                ch1_req_burst_i,
  input  mam_req_pkg::beats_t ch1_req_beats_i,
  input  logic                ch1_write_valid_i,
  input  logic [XLEN-1:0]     ch1_write_data_i,
  output logic                ch1_write_ready_o,
  output logic                ch1_read_valid_o,
  output logic [XLEN-1:0]     ch1_read_data_o,
  input  logic                ch1_read_credit_i
);
  import ahb3_pkg::*;
  import mam_req_pkg::*;

  // Arbiter to master
  logic            mst_req_valid;
  logic            mst_req_ready;
  logic            mst_req_we;
  logic [PLEN-1:0] mst_req_addr;
  logic            mst_req_burst;
  beats_t          mst_req_beats;
  logic            mst_write_valid;
  logic [XLEN-1:0] mst_write_data;
  logic            mst_write_ready;
  logic            mst_read_valid;
  logic [XLEN-1:0] mst_read_data;
  logic            mst_read_ready;

  // AHB3 bus
  logic            ahb_hsel;
  logic [PLEN-1:0] ahb_haddr;
  logic [XLEN-1:0] ahb_hwdata;
  logic [XLEN-1:0] ahb_hrdata;
  logic            ahb_hwrite;
  hburst_t         ahb_hburst;
  htrans_t         ahb_htrans;
  logic            ahb_hready;

  mam_arbiter #(
    .CREDITS (CREDITS),
    .XLEN    (XLEN),
    .PLEN    (PLEN)
  ) i_arbiter (
    .clk_i              (clk_i),
    .rst_i              (rst_i),
    .chan_req_valid_i   ({ch1_req_valid_i, ch0_req_valid_i}),
    .chan_req_ready_o   ({ch1_req_ready_o, ch0_req_ready_o}),
    .chan_req_we_i      ({ch1_req_we_i, ch0_req_we_i}),
    .chan_req_addr_i    ({ch1_req_addr_i, ch0_req_addr_i}),
    .chan_req_burst_i   ({ch1_req_burst_i, ch0_req_burst_i}),
    .chan_req_beats_i   ({ch1_req_beats_i, ch0_req_beats_i}),
    .chan_write_valid_i ({ch1_write_valid_i, ch0_write_valid_i}),
    .chan_write_data_i  ({ch1_write_data_i, ch0_write_data_i}),
    .chan_write_ready_o ({ch1_write_ready_o, ch0_write_ready_o}),
    .chan_read_valid_o  ({ch1_read_valid_o, ch0_read_valid_o}),
    .chan_read_data_o   ({ch1_read_data_o, ch0_read_data_o}),
    .chan_read_credit_i ({ch1_read_credit_i, ch0_read_credit_i}),
    .mst_req_valid_o    (mst_req_valid),
    .mst_req_ready_i    (mst_req_ready),
    .mst_req_we_o       (mst_req_we),
    .mst_req_addr_o     (mst_req_addr),
    .mst_req_burst_o    (mst_req_burst),
    .mst_req_beats_o    (mst_req_beats),
    .mst_write_valid_o  (mst_write_valid),
    .mst_write_data_o   (mst_write_data),
    .mst_write_ready_i  (mst_write_ready),
    .mst_read_valid_i   (mst_read_valid),
    .mst_read_data_i    (mst_read_data),
    .mst_read_ready_o   (mst_read_ready)
  );

  mam_ahb_master #(
    .XLEN (XLEN),
    .PLEN (PLEN)
  ) i_master (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .req_valid_i   (mst_req_valid),
    .req_ready_o   (mst_req_ready),
    .req_we_i      (mst_req_we),
    .req_addr_i    (mst_req_addr),
    .req_burst_i   (mst_req_burst),
    .req_beats_i   (mst_req_beats),
    .write_valid_i (mst_write_valid),
    .write_data_i  (mst_write_data),
    .write_ready_o (mst_write_ready),
    .read_valid_o  (mst_read_valid),
    .read_data_o   (mst_read_data),
    .read_ready_i  (mst_read_ready),
    .ahb_hsel_o    (ahb_hsel),
    .ahb_haddr_o   (ahb_haddr),
    .ahb_hwdata_o  (ahb_hwdata),
    .ahb_hrdata_i  (ahb_hrdata),
    .ahb_hwrite_o  (ahb_hwrite),
    .ahb_hsize_o   (),           // Single slave is word-only
    .ahb_hburst_o  (ahb_hburst),
    .ahb_htrans_o  (ahb_htrans),
    .ahb_hready_i  (ahb_hready)
  );

  mam_ahb_sram #(
    .XLEN        (XLEN),
    .PLEN        (PLEN),
    .MEM_WORDS   (MEM_WORDS),
    .WAIT_STATES (WAIT_STATES)
  ) i_sram (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .ahb_hsel_i   (ahb_hsel),
    .ahb_haddr_i  (ahb_haddr),
    .ahb_hwdata_i (ahb_hwdata),
    .ahb_hwrite_i (ahb_hwrite),
    .ahb_htrans_i (ahb_htrans),
    .ahb_hburst_i (ahb_hburst),
    .ahb_hrdata_o (ahb_hrdata),
    .ahb_hready_o (ahb_hready)
  );

endmodule

// ==== sim/mam_sys_tb_model.svh ====
// Shadow memory and reference read model that the memory-access testbench includes in its body
`ifndef MAM_SYS_TB_MODEL_SVH
`define MAM_SYS_TB_MODEL_SVH

  // One entry per SRAM word, filled from accepted write beats
  logic [XLEN-1:0] shadow_mem   [MEM_WORDS];
  logic            shadow_known [MEM_WORDS];

  // Maps a byte address to an SRAM word index within the memory depth
  function automatic int word_index(input logic [PLEN-1:0] addr);
    return int'((addr / PLEN'(XLEN / 8)) % PLEN'(MEM_WORDS));
  endfunction

  task automatic clear_shadow();
    for (int i = 0; i < MEM_WORDS; i++) begin
      shadow_mem[i]   = '0;
      shadow_known[i] = 1'b0;
    end
  endtask

  task automatic shadow_write(input logic [PLEN-1:0] addr, input logic [XLEN-1:0] data);
    shadow_mem[word_index(addr)]   = data;
    shadow_known[word_index(addr)] = 1'b1;
  endtask

  function automatic logic word_known(input logic [PLEN-1:0] addr);
    return shadow_known[word_index(addr)];
  endfunction

  // Expected read data is the last word written to that address
  function automatic logic [XLEN-1:0] expected_word(input logic [PLEN-1:0] addr);
    return shadow_mem[word_index(addr)];
  endfunction

`endif

// ==== sim/mam_sys_tb.sv ====
// Testbench for the memory-access subsystem that checks both channels against a shadow model
module mam_sys_tb;
  import mam_req_pkg::*;

  localparam int XLEN         = 32;
  localparam int PLEN         = 32;
  localparam int MEM_WORDS    = 256;
  localparam int WAIT_STATES  = 2;
  localparam int CREDITS      = 2;
  localparam int unsigned SEED = 32'h7ef6;
  localparam int SAMPLE_DLY   = 1;  // Mid low phase when all inputs have settled
  localparam int ITERS        = 4;  // Bursts per channel in the concurrent test
  localparam int MAX_LEN      = 8;
  localparam int REGION_WORDS = 16;
  localparam int HOLD_CYCLES  = 20;
  localparam int TOTAL_BEATS  = 2 + 16 + 2 * ITERS * 2 * MAX_LEN + 12 + 8;
  localparam int TIMEOUT      = TOTAL_BEATS * (WAIT_STATES + 6) * 4 + 200 * 4;

  logic             clk;
  logic             rst;
  logic [NCHAN-1:0] req_valid;
  logic [NCHAN-1:0] req_ready;
  logic [NCHAN-1:0] req_we;
  logic [NCHAN-1:0] req_burst;
  logic [PLEN-1:0]  req_addr [NCHAN];
  beats_t           req_beats [NCHAN];
  logic [NCHAN-1:0] write_valid;
  logic [NCHAN-1:0] write_ready;
  logic [XLEN-1:0]  write_data [NCHAN];
  logic [NCHAN-1:0] read_valid;
  logic [XLEN-1:0]  read_data [NCHAN];
  logic [NCHAN-1:0] read_credit;
  logic [NCHAN-1:0] hold_credit;

  int              balance [NCHAN];    // Credits the DUT should still hold
  int              owed [NCHAN];       // Delivered beats not yet returned as credit
  int              beats_seen [NCHAN];
  int              rd_left [NCHAN];
  int              rd_idx [NCHAN];
  logic [PLEN-1:0] rd_base [NCHAN];

  `include "mam_sys_tb_model.svh"

  mam_sys_top #(
    .XLEN        (XLEN),
    .PLEN        (PLEN),
    .MEM_WORDS   (MEM_WORDS),
    .WAIT_STATES (WAIT_STATES),
    .CREDITS     (CREDITS)
  ) i_mam_sys_top (
    .clk_i             (clk),
    .rst_i             (rst),
    .ch0_req_valid_i   (req_valid[0]),
    .ch0_req_ready_o   (req_ready[0]),
    .ch0_req_we_i      (req_we[0]),
    .ch0_req_addr_i    (req_addr[0]),
    .ch0_req_burst_i   (req_burst[0]),
    .ch0_req_beats_i   (req_beats[0]),
    .ch0_write_valid_i (write_valid[0]),
    .ch0_write_data_i  (write_data[0]),
    .ch0_write_ready_o (write_ready[0]),
    .ch0_read_valid_o  (read_valid[0]),
    .ch0_read_data_o   (read_data[0]),
    .ch0_read_credit_i (read_credit[0]),
    .ch1_req_valid_i   (req_valid[1]),
    .ch1_req_ready_o   (req_ready[1]),
    .ch1_req_we_i      (req_we[1]),
    .ch1_req_addr_i    (req_addr[1]),
    .ch1_req_burst_i   (req_burst[1]),
    .ch1_req_beats_i   (req_beats[1]),
    .ch1_write_valid_i (write_valid[1]),
    .ch1_write_data_i  (write_data[1]),
    .ch1_write_ready_o (write_ready[1]),
    .ch1_read_valid_o  (read_valid[1]),
    .ch1_read_data_o   (read_data[1]),
    .ch1_read_credit_i (read_credit[1])
  );

  initial clk = 1'b0;
  always #2 clk = ~clk; // 4 unit period

  task automatic stop_with_error(input string msg);
    $display("%s", msg);
    $display("TEST RESULT: FAIL");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_word(input chan_idx_t ch, input logic [PLEN-1:0] addr,
                            input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp);
    if (got !== exp) begin
      stop_with_error($sformatf("[FAIL] %0t ch%0d read at 0x%08h: got 0x%08h, expected 0x%08h",
                                $time, ch, addr, got, exp));
    end
  endtask

  task automatic check_credit(input chan_idx_t ch, input int credit_left);
    if (credit_left <= 0) begin
      stop_with_error($sformatf("[FAIL] %0t ch%0d got a read beat with no credit left",
                                $time, ch));
    end
  endtask

  task automatic check_count(input chan_idx_t ch, input beats_t got, input beats_t exp);
    if (got !== exp) begin
      stop_with_error($sformatf("[FAIL] %0t ch%0d saw %0d read beats, expected %0d",
                                $time, ch, got, exp));
    end
  endtask

  task automatic check_flag(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      stop_with_error($sformatf("[FAIL] %0t %s is %b, expected %b", $time, what, got, exp));
    end
  endtask

  // Holds a request until the channel accepts it and returns on the next falling edge
  task automatic issue_req(input chan_idx_t ch, input logic we, input logic [PLEN-1:0] addr,
                           input logic burst, input int n);
    logic taken;
    taken         = 1'b0;
    req_we[ch]    = we;
    req_addr[ch]  = addr;
    req_burst[ch] = burst;
    req_beats[ch] = beats_t'(n);
    req_valid[ch] = 1'b1;
    while (!taken) begin
      #SAMPLE_DLY;
      taken = req_ready[ch];
      @(negedge clk);
    end
    req_valid[ch] = 1'b0;
  endtask

  task automatic stream_write(input chan_idx_t ch, input logic [PLEN-1:0] base, input int n);
    logic [XLEN-1:0] word;
    logic            taken;
    for (int k = 0; k < n; k++) begin
      word            = XLEN'($urandom());
      write_data[ch]  = word;
      write_valid[ch] = 1'b1;
      taken           = 1'b0;
      while (!taken) begin
        #SAMPLE_DLY;
        taken = write_ready[ch];
        @(negedge clk);
      end
      shadow_write(base + PLEN'(k * (XLEN / 8)), word); // Beat k lands one word further on
    end
    write_valid[ch] = 1'b0;
  endtask

  task automatic write_words(input chan_idx_t ch, input logic [PLEN-1:0] base,
                             input logic burst, input int n);
    issue_req(ch, 1'b1, base, burst, n);
    stream_write(ch, base, n);
  endtask

  // Returns once the last read beat of the request has been checked
  task automatic read_words(input chan_idx_t ch, input logic [PLEN-1:0] base,
                            input logic burst, input int n);
    rd_base[ch] = base;
    rd_idx[ch]  = 0;
    rd_left[ch] = n;
    issue_req(ch, 1'b0, base, burst, n);
    while (rd_left[ch] != 0) begin
      @(negedge clk);
    end
  endtask

  task automatic random_traffic(input chan_idx_t ch, input logic [PLEN-1:0] region);
    int              len;
    int              ofs;
    logic            burst;
    logic [PLEN-1:0] base;
    for (int i = 0; i < ITERS; i++) begin
      len   = int'($urandom_range(MAX_LEN, 1));
      ofs   = int'($urandom_range(REGION_WORDS - len, 0));
      burst = (len > 1) || ($urandom_range(1, 0) == 1);
      base  = region + PLEN'(ofs * (XLEN / 8));
      write_words(ch, base, burst, len);
      read_words(ch, base, burst, len);
    end
  endtask

  // Gives back one credit per delivered beat after a random gap
  task automatic return_credits();
    int gap [NCHAN];
    for (int c = 0; c < NCHAN; c++) begin
      gap[c] = 0;
    end
    forever begin
      @(negedge clk);
      for (int c = 0; c < NCHAN; c++) begin
        read_credit[c] = 1'b0;
        if (gap[c] > 0) begin
          gap[c]--;
        end else if (owed[c] > 0 && !hold_credit[c]) begin
          read_credit[c] = 1'b1;
          owed[c]--;
          gap[c] = int'($urandom_range(4, 0));
        end
      end
    end
  endtask

  task automatic compare_beat(input chan_idx_t ch);
    logic [PLEN-1:0] addr;
    check_credit(ch, balance[ch]);
    balance[ch]--;
    owed[ch]++;
    beats_seen[ch]++;
    if (rd_left[ch] == 0) begin
      stop_with_error($sformatf("Channel %0d got a read beat with no read outstanding", ch));
    end
    addr = rd_base[ch] + PLEN'(rd_idx[ch] * (XLEN / 8));
    if (!word_known(addr)) begin
      stop_with_error($sformatf("Channel %0d read address 0x%08h that was never written",
                                ch, addr));
    end
    check_word(ch, addr, read_data[ch], expected_word(addr));
    rd_idx[ch]++;
    rd_left[ch]--;
  endtask

  // Compare process counting a credit pulse at the same edge as a beat
  always @(negedge clk) begin
    #SAMPLE_DLY;
    if (!rst) begin
      for (int c = 0; c < NCHAN; c++) begin
        if (read_valid[c]) begin
          compare_beat(chan_idx_t'(c));
        end
        if (read_credit[c]) begin
          balance[c]++;
        end
      end
    end
  end

  initial begin
    #TIMEOUT;
    $display("Timeout: the run did not finish within %0d time units", TIMEOUT);
    $display("TEST RESULT: FAIL");
    $fatal(1, "watchdog expired");
  end

  initial begin
    int start;
    void'($urandom(SEED));
    rst         = 1'b1;
    req_valid   = '0;
    req_we      = '0;
    req_burst   = '0;
    write_valid = '0;
    read_credit = '0;
    hold_credit = '0;
    for (int c = 0; c < NCHAN; c++) begin
      req_addr[c]   = '0;
      req_beats[c]  = '0;
      write_data[c] = '0;
      balance[c]    = CREDITS;
      owed[c]       = 0;
      beats_seen[c] = 0;
      rd_left[c]    = 0;
      rd_idx[c]     = 0;
      rd_base[c]    = '0;
    end
    clear_shadow();
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    fork
      return_credits();
    join_none

    #SAMPLE_DLY;
    check_flag("ch0 req_ready after reset", req_ready[0], 1'b1);
    check_flag("ch1 req_ready after reset", req_ready[1], 1'b0);
    check_flag("write_ready after reset", |write_ready, 1'b0);
    check_flag("read_valid after reset", |read_valid, 1'b0);
    @(negedge clk);

    // Single write then single read
    write_words(0, 32'h10, 1'b0, 1);
    read_words(0, 32'h10, 1'b0, 1);

    // Eight beat bursts
    write_words(0, 32'h100, 1'b1, 8);
    read_words(0, 32'h100, 1'b1, 8);

    // Both channels at once on disjoint regions
    fork
      random_traffic(0, 32'h200);
      random_traffic(1, 32'h300);
    join

    // Withheld credits stall channel 0 after CREDITS beats
    while (owed[0] != 0 || balance[0] != CREDITS) begin
      @(negedge clk);
    end
    write_words(0, 32'h40, 1'b1, 6);
    hold_credit[0] = 1'b1;
    start = beats_seen[0];
    fork
      read_words(0, 32'h40, 1'b1, 6);
      begin
        while (beats_seen[0] - start < CREDITS) begin
          @(negedge clk);
        end
        repeat (HOLD_CYCLES) @(negedge clk);
        check_count(0, beats_t'(beats_seen[0] - start), beats_t'(CREDITS));
        hold_credit[0] = 1'b0;
      end
    join

    // One beat bursts mixed with single accesses
    write_words(1, 32'h80, 1'b1, 1);
    read_words(1, 32'h80, 1'b0, 1);
    write_words(1, 32'h84, 1'b0, 1);
    read_words(1, 32'h84, 1'b1, 1);

    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

// ==== mam_sys.f ====
+incdir+sim
verilog/ahb3_pkg.sv
verilog/mam_req_pkg.sv
verilog/mam_ahb_master.sv
verilog/mam_arbiter.sv
verilog/mam_ahb_sram.sv
verilog/mam_sys_top.sv
sim/mam_sys_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       := mam_sys_tb
RTL_TOP   := mam_sys_top
FILELIST  := mam_sys.f
OBJ_DIR   := obj_dir
LOG       := sim.log
VFLAGS    := --binary --timing --assert -Wno-fatal -j 0
LINTFLAGS := --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "TEST RESULT: PASS" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
